// ==== pipeline_types.sv ====
package pipeline_types;

    // lane count, fixed by the two ALU lanes
    localparam int unsigned ISSUE_WIDTH = 2;

    typedef logic [31:0] bus32_t;
    typedef logic [63:0] bus64_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic signed [11:0] imm12_t;

    // shifts take opb[4:0], slt is a signed compare
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // decoded op from the instruction buffer
    typedef struct packed {
        logic valid;
        bus32_t pc;
        alu_op_t op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic use_imm;
        imm12_t imm;
    } micro_op_t;

    // op with resolved operands, one per lane
    typedef struct packed {
        logic valid;
        bus32_t pc;
        alu_op_t op;
        reg_addr_t rd;
        bus32_t opa;
        bus32_t opb;
    } issue_t;

    // in-flight result seen by dispatch
    typedef struct packed {
        logic valid;
        reg_addr_t rd;
        bus32_t data;
    } push_forward_t;

    typedef struct packed {
        logic valid;
        bus32_t pc;
        reg_addr_t rd;
        bus32_t wdata;
    } commit_t;

endpackage

// ==== regs_file.sv ====
module regs_file (
    input logic clk,
    input logic rst_n_i,

    input logic [pipeline_types::ISSUE_WIDTH-1:0] we_i,
    input pipeline_types::reg_addr_t [pipeline_types::ISSUE_WIDTH-1:0] waddr_i,
    input pipeline_types::bus32_t [pipeline_types::ISSUE_WIDTH-1:0] wdata_i,

    input pipeline_types::reg_addr_t [2*pipeline_types::ISSUE_WIDTH-1:0] read_addr_i,
    output pipeline_types::bus32_t [2*pipeline_types::ISSUE_WIDTH-1:0] read_data_o
);
    import pipeline_types::*;

    localparam int unsigned NUM_REGS = 32;

    bus32_t regs_q [NUM_REGS];

    // later port overrides earlier one, r0 never written
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            for (int w = 0; w < ISSUE_WIDTH; w++) begin
                if (we_i[w] && (waddr_i[w] != '0)) begin
                    regs_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < 2 * ISSUE_WIDTH; r++) begin
            if (read_addr_i[r] == '0) begin
                read_data_o[r] = '0;
            end else begin
                read_data_o[r] = regs_q[read_addr_i[r]];
            end
        end
    end

endmodule

// ==== dispatch.sv ====
module dispatch (
    input logic clk,
    input logic rst_n_i,

    // upstream bundle
    input pipeline_types::micro_op_t [pipeline_types::ISSUE_WIDTH-1:0] bundle_i,
    input logic bundle_valid_i,
    output logic bundle_ready_o,

    // forwarding sources
    input pipeline_types::push_forward_t [pipeline_types::ISSUE_WIDTH-1:0] ex_pf_i,
    input pipeline_types::push_forward_t [pipeline_types::ISSUE_WIDTH-1:0] wb_pf_i,

    // register file
    output pipeline_types::reg_addr_t [2*pipeline_types::ISSUE_WIDTH-1:0] read_addr_o,
    input pipeline_types::bus32_t [2*pipeline_types::ISSUE_WIDTH-1:0] read_data_i,

    output pipeline_types::issue_t [pipeline_types::ISSUE_WIDTH-1:0] issue_o
);
    import pipeline_types::*;

    logic ready_en_q;
    logic hold_valid_q;
    micro_op_t hold_op_q;

    logic accept;
    logic split;
    micro_op_t [ISSUE_WIDTH-1:0] slot_op;
    issue_t [ISSUE_WIDTH-1:0] issue_d;
    issue_t [ISSUE_WIDTH-1:0] issue_q;

    function automatic logic reads_reg(input micro_op_t uop, input reg_addr_t addr);
        return (uop.rs1 == addr) || (!uop.use_imm && (uop.rs2 == addr));
    endfunction

    // execute beats write-back beats the register file, lane 1 beats lane 0
    function automatic bus32_t fwd_select(
        input reg_addr_t addr,
        input bus32_t rf_data,
        input push_forward_t [ISSUE_WIDTH-1:0] ex_pf,
        input push_forward_t [ISSUE_WIDTH-1:0] wb_pf
    );
        bus32_t value;
        value = rf_data;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (wb_pf[i].valid && (wb_pf[i].rd == addr)) begin
                value = wb_pf[i].data;
            end
        end
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (ex_pf[i].valid && (ex_pf[i].rd == addr)) begin
                value = ex_pf[i].data;
            end
        end
        if (addr == '0) begin
            value = '0;
        end
        return value;
    endfunction

    assign bundle_ready_o = ready_en_q && !hold_valid_q;
    assign accept = bundle_valid_i && bundle_ready_o;

    // lane 1 needs lane 0's result inside the same bundle
    assign split = bundle_i[0].valid && bundle_i[1].valid && (bundle_i[0].rd != '0)
                   && reads_reg(bundle_i[1], bundle_i[0].rd);

    always_comb begin
        if (hold_valid_q) begin
            slot_op[0] = '0;
            slot_op[1] = hold_op_q;
            slot_op[1].valid = 1'b1;
        end else begin
            slot_op = bundle_i;
            slot_op[0].valid = accept && bundle_i[0].valid;
            slot_op[1].valid = accept && bundle_i[1].valid && !split;
        end
    end

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            read_addr_o[2*i] = slot_op[i].rs1;
            read_addr_o[2*i+1] = slot_op[i].rs2;

            issue_d[i].valid = slot_op[i].valid;
            issue_d[i].pc = slot_op[i].pc;
            issue_d[i].op = slot_op[i].op;
            issue_d[i].rd = slot_op[i].rd;
            issue_d[i].opa = fwd_select(slot_op[i].rs1, read_data_i[2*i], ex_pf_i, wb_pf_i);
            if (slot_op[i].use_imm) begin
                issue_d[i].opb = {{20{slot_op[i].imm[11]}}, slot_op[i].imm};
            end else begin
                issue_d[i].opb = fwd_select(slot_op[i].rs2, read_data_i[2*i+1],
                                            ex_pf_i, wb_pf_i);
            end
        end
    end

    // ready rises on the first edge after reset release
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_en_q <= 1'b0;
            hold_valid_q <= 1'b0;
            issue_q <= '0;
        end else begin
            ready_en_q <= 1'b1;
            hold_valid_q <= accept && split;
            issue_q <= issue_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && split) begin
            hold_op_q <= bundle_i[1];
        end
    end

    assign issue_o = issue_q;

endmodule

// ==== alu_lane.sv ====
module alu_lane (
    input pipeline_types::issue_t issue_i,

    output pipeline_types::push_forward_t pf_o,
    output pipeline_types::bus32_t result_o
);
    import pipeline_types::*;

    bus32_t result;
    logic [4:0] shamt;

    assign shamt = issue_i.opb[4:0];

    always_comb begin
        case (issue_i.op)
            ALU_ADD: begin
                result = issue_i.opa + issue_i.opb;
            end
            ALU_SUB: begin
                result = issue_i.opa - issue_i.opb;
            end
            ALU_AND: begin
                result = issue_i.opa & issue_i.opb;
            end
            ALU_OR: begin
                result = issue_i.opa | issue_i.opb;
            end
            ALU_XOR: begin
                result = issue_i.opa ^ issue_i.opb;
            end
            ALU_SLL: begin
                result = issue_i.opa << shamt;
            end
            ALU_SRL: begin
                result = issue_i.opa >> shamt;
            end
            ALU_SLT: begin
                result = bus32_t'($signed(issue_i.opa) < $signed(issue_i.opb));
            end
        endcase
    end

    assign result_o = result;

    // r0 results are never forwarded
    assign pf_o.valid = issue_i.valid && (issue_i.rd != '0);
    assign pf_o.rd = issue_i.rd;
    assign pf_o.data = result;

endmodule

// ==== wb_commit.sv ====
module wb_commit (
    input logic clk,
    input logic rst_n_i,

    // execute stage
    input pipeline_types::issue_t [pipeline_types::ISSUE_WIDTH-1:0] issue_i,
    input pipeline_types::bus32_t [pipeline_types::ISSUE_WIDTH-1:0] result_i,

    output pipeline_types::push_forward_t [pipeline_types::ISSUE_WIDTH-1:0] wb_pf_o,

    // register file writes
    output logic [pipeline_types::ISSUE_WIDTH-1:0] we_o,
    output pipeline_types::reg_addr_t [pipeline_types::ISSUE_WIDTH-1:0] waddr_o,
    output pipeline_types::bus32_t [pipeline_types::ISSUE_WIDTH-1:0] wdata_o,

    output pipeline_types::commit_t [pipeline_types::ISSUE_WIDTH-1:0] commit_o,
    output pipeline_types::bus64_t retire_cnt_o
);
    import pipeline_types::*;

    localparam int unsigned CNT_W = $clog2(ISSUE_WIDTH + 1);

    commit_t [ISSUE_WIDTH-1:0] commit_q;
    bus64_t retire_cnt_q;
    logic [ISSUE_WIDTH-1:0] lane_we;
    logic [CNT_W-1:0] commit_count;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_q <= '0;
        end else begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                commit_q[i].valid <= issue_i[i].valid;
                commit_q[i].pc <= issue_i[i].pc;
                commit_q[i].rd <= issue_i[i].rd;
                commit_q[i].wdata <= result_i[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            lane_we[i] = commit_q[i].valid && (commit_q[i].rd != '0);
            wb_pf_o[i].valid = lane_we[i];
            wb_pf_o[i].rd = commit_q[i].rd;
            wb_pf_o[i].data = commit_q[i].wdata;
            waddr_o[i] = commit_q[i].rd;
            wdata_o[i] = commit_q[i].wdata;
        end
        // younger lane owns a shared destination
        we_o = lane_we;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            for (int j = i + 1; j < ISSUE_WIDTH; j++) begin
                if (lane_we[j] && (commit_q[j].rd == commit_q[i].rd)) begin
                    we_o[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        commit_count = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            commit_count = commit_count + CNT_W'(commit_q[i].valid);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_cnt_q <= '0;
        end else begin
            retire_cnt_q <= retire_cnt_q + bus64_t'(commit_count);
        end
    end

    assign commit_o = commit_q;
    assign retire_cnt_o = retire_cnt_q;

endmodule

// ==== backend_top.sv ====
module backend_top (
    input logic clk,
    input logic rst_n_i,

    // from instruction buffer
    input pipeline_types::micro_op_t [pipeline_types::ISSUE_WIDTH-1:0] bundle_i,
    input logic bundle_valid_i,
    output logic bundle_ready_o,

    // retirement
    output pipeline_types::commit_t [pipeline_types::ISSUE_WIDTH-1:0] commit_o,
    output pipeline_types::bus64_t retire_cnt_o
);
    import pipeline_types::*;

    // forwarding
    push_forward_t [ISSUE_WIDTH-1:0] ex_pf;
    push_forward_t [ISSUE_WIDTH-1:0] wb_pf;

    // register file reads
    reg_addr_t [2*ISSUE_WIDTH-1:0] read_addr;
    bus32_t [2*ISSUE_WIDTH-1:0] read_data;

    // execute
    issue_t [ISSUE_WIDTH-1:0] issue;
    bus32_t [ISSUE_WIDTH-1:0] result;

    // write-back
    logic [ISSUE_WIDTH-1:0] reg_we;
    reg_addr_t [ISSUE_WIDTH-1:0] reg_waddr;
    bus32_t [ISSUE_WIDTH-1:0] reg_wdata;

    dispatch u_dispatch (
        .clk,
        .rst_n_i,
        .bundle_i,
        .bundle_valid_i,
        .bundle_ready_o,
        .ex_pf_i(ex_pf),
        .wb_pf_i(wb_pf),
        .read_addr_o(read_addr),
        .read_data_i(read_data),
        .issue_o(issue)
    );

    alu_lane u_alu_lane0 (
        .issue_i(issue[0]),
        .pf_o(ex_pf[0]),
        .result_o(result[0])
    );

    alu_lane u_alu_lane1 (
        .issue_i(issue[1]),
        .pf_o(ex_pf[1]),
        .result_o(result[1])
    );

    wb_commit u_wb_commit (
        .clk,
        .rst_n_i,
        .issue_i(issue),
        .result_i(result),
        .wb_pf_o(wb_pf),
        .we_o(reg_we),
        .waddr_o(reg_waddr),
        .wdata_o(reg_wdata),
        .commit_o,
        .retire_cnt_o
    );

    regs_file u_regs_file (
        .clk,
        .rst_n_i,
        .we_i(reg_we),
        .waddr_i(reg_waddr),
        .wdata_i(reg_wdata),
        .read_addr_i(read_addr),
        .read_data_o(read_data)
    );

endmodule

// ==== tb_backend_top.sv ====
module tb_backend_top;
    timeunit 1ns;
    timeprecision 1ps;

    import pipeline_types::*;

    localparam int unsigned CLK_PERIOD = 8;
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned NUM_BUNDLES = 2000;
    localparam int unsigned TIMEOUT_NS = NUM_BUNDLES * 3 * CLK_PERIOD
                                         + (RESET_CYCLES + 10) * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED = 32'hf05e_382a;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // due is the cycle count at which the record shows on commit_o
    typedef struct packed {
        int unsigned due;
        logic slot;
        commit_t rec;
    } exp_commit_t;

    logic clk;
    logic rst_n_i;
    micro_op_t [ISSUE_WIDTH-1:0] bundle_i;
    logic bundle_valid_i;
    logic bundle_ready_o;
    commit_t [ISSUE_WIDTH-1:0] commit_o;
    bus64_t retire_cnt_o;

    logic [31:0] lfsr_state;
    int unsigned cyc = 0;
    bus32_t gold_regs [32];
    exp_commit_t exp_q [$];
    bus64_t model_count;
    bus64_t retired;
    bus32_t next_pc;
    int unsigned accepted;
    logic hold_expected;
    logic pending;

    backend_top dut_i (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .bundle_i(bundle_i),
        .bundle_valid_i(bundle_valid_i),
        .bundle_ready_o(bundle_ready_o),
        .commit_o(commit_o),
        .retire_cnt_o(retire_cnt_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] value;
        value = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // mostly r0..r3 so that hazards are frequent
    function automatic reg_addr_t pick_reg();
        if (rand_bits(2) != 0) begin
            return reg_addr_t'(rand_bits(2));
        end
        return reg_addr_t'(rand_bits(5));
    endfunction

    function automatic bus32_t alu_ref(input alu_op_t op, input bus32_t a, input bus32_t b);
        bus32_t res;
        case (op)
            ALU_ADD: res = a + b;
            ALU_SUB: res = a - b;
            ALU_AND: res = a & b;
            ALU_OR: res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_SLL: res = a << b[4:0];
            ALU_SRL: res = a >> b[4:0];
            default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        return res;
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("MISMATCH %s: got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
        abort_run();
    endtask

    task automatic model_exec(input micro_op_t uop, input logic slot, input int unsigned due);
        bus32_t opa;
        bus32_t opb;
        exp_commit_t entry;
        opa = gold_regs[uop.rs1];
        if (uop.use_imm) begin
            opb = {{20{uop.imm[11]}}, uop.imm};
        end else begin
            opb = gold_regs[uop.rs2];
        end
        entry.due = due;
        entry.slot = slot;
        entry.rec.valid = 1'b1;
        entry.rec.pc = uop.pc;
        entry.rec.rd = uop.rd;
        entry.rec.wdata = alu_ref(uop.op, opa, opb);
        // r0 keeps reading zero
        if (uop.rd != '0) begin
            gold_regs[uop.rd] = entry.rec.wdata;
        end
        exp_q.push_back(entry);
        model_count++;
    endtask

    // program order, a dependent lane 1 trails by one cycle
    task automatic accept_bundle();
        logic split;
        split = bundle_i[0].valid && bundle_i[1].valid && (bundle_i[0].rd != '0)
                && ((bundle_i[1].rs1 == bundle_i[0].rd)
                    || (!bundle_i[1].use_imm && (bundle_i[1].rs2 == bundle_i[0].rd)));
        if (bundle_i[0].valid) begin
            model_exec(bundle_i[0], 1'b0, cyc + 2);
        end
        if (bundle_i[1].valid) begin
            model_exec(bundle_i[1], 1'b1, split ? cyc + 3 : cyc + 2);
        end
        hold_expected = split;
        accepted++;
    endtask

    task automatic drive_bundle();
        logic [1:0] lanes;
        // a stalled bundle stays as it is
        if (!pending) begin
            bundle_valid_i = (rand_bits(2) != 0);
            lanes = 2'(rand_bits(2));
            for (int l = 0; l < ISSUE_WIDTH; l++) begin
                bundle_i[l].valid = lanes[l];
                bundle_i[l].pc = next_pc;
                bundle_i[l].op = alu_op_t'(rand_bits(3));
                bundle_i[l].rd = pick_reg();
                bundle_i[l].rs1 = pick_reg();
                bundle_i[l].rs2 = pick_reg();
                bundle_i[l].use_imm = rand_bits(1) != 0;
                bundle_i[l].imm = imm12_t'(rand_bits(12));
                next_pc = next_pc + 32'd4;
            end
        end
    endtask

    task automatic check_reset_state();
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            assert (!commit_o[s].valid) else begin
                report_mismatch($sformatf("commit_o[%0d].valid", s), commit_o[s].valid, 0);
            end
        end
        assert (retire_cnt_o == '0) else begin
            report_mismatch("retire_cnt_o", retire_cnt_o, 0);
        end
        assert (!bundle_ready_o) else begin
            report_mismatch("bundle_ready_o", bundle_ready_o, 0);
        end
    endtask

    task automatic check_outputs(input logic exp_ready);
        exp_commit_t head;
        logic [ISSUE_WIDTH-1:0] exp_valid;
        commit_t [ISSUE_WIDTH-1:0] exp_rec;
        exp_valid = '0;
        exp_rec = '0;
        while ((exp_q.size() > 0) && (exp_q[0].due == cyc)) begin
            head = exp_q.pop_front();
            exp_valid[head.slot] = 1'b1;
            exp_rec[head.slot] = head.rec;
        end
        assert (retire_cnt_o == retired) else begin
            report_mismatch("retire_cnt_o", retire_cnt_o, retired);
        end
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            assert (commit_o[s].valid == exp_valid[s]) else begin
                report_mismatch($sformatf("commit_o[%0d].valid", s), commit_o[s].valid,
                                exp_valid[s]);
            end
            if (exp_valid[s]) begin
                assert (commit_o[s].pc == exp_rec[s].pc) else begin
                    report_mismatch($sformatf("commit_o[%0d].pc", s), commit_o[s].pc,
                                    exp_rec[s].pc);
                end
                assert (commit_o[s].rd == exp_rec[s].rd) else begin
                    report_mismatch($sformatf("commit_o[%0d].rd", s), commit_o[s].rd,
                                    exp_rec[s].rd);
                end
                assert (commit_o[s].wdata == exp_rec[s].wdata) else begin
                    report_mismatch($sformatf("commit_o[%0d].wdata", s), commit_o[s].wdata,
                                    exp_rec[s].wdata);
                end
                retired++;
            end
        end
        assert (bundle_ready_o == exp_ready) else begin
            report_mismatch("bundle_ready_o", bundle_ready_o, exp_ready);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
        abort_run();
    end

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        bundle_i = '0;
        bundle_valid_i = 1'b0;
        lfsr_state = LFSR_SEED;
        model_count = '0;
        retired = '0;
        next_pc = 32'h0000_1000;
        accepted = 0;
        hold_expected = 1'b0;
        pending = 1'b0;
        for (int r = 0; r < 32; r++) begin
            gold_regs[r] = '0;
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_reset_state();
        end
        rst_n_i = 1'b1;

        while (accepted < NUM_BUNDLES) begin
            @(negedge clk);
            check_outputs(!hold_expected);
            hold_expected = 1'b0;
            drive_bundle();
            if (bundle_valid_i && bundle_ready_o) begin
                accept_bundle();
            end
            pending = bundle_valid_i && !bundle_ready_o;
        end

        // drain the last commits
        repeat (4) begin
            @(negedge clk);
            check_outputs(!hold_expected);
            hold_expected = 1'b0;
            bundle_valid_i = 1'b0;
        end

        assert (exp_q.size() == 0) else begin
            $display("ERROR: %0d expected commits never appeared", exp_q.size());
            abort_run();
        end
        assert (retire_cnt_o == model_count) else begin
            report_mismatch("retire_cnt_o", retire_cnt_o, model_count);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
pipeline_types.sv
regs_file.sv
dispatch.sv
alu_lane.sv
wb_commit.sv
backend_top.sv
tb_backend_top.sv

// ==== Bender.yml ====
package:
  name: backend_top

sources:
  - pipeline_types.sv
  - regs_file.sv
  - dispatch.sv
  - alu_lane.sv
  - wb_commit.sv
  - backend_top.sv
  - target: test
    files:
      - tb_backend_top.sv
